// ==== Makefile ====
VERILATOR  := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := pet_bus_tb
RTL_TOP    := pet_bus_top
FILELIST   := pet_bus.f
OBJ_DIR    := obj_dir
LOG        := sim.log

SOURCES    := $(filter %.sv,$(shell cat $(FILELIST)))
RTL_FILES  := $(filter verilog/%.sv,$(SOURCES))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) verilog/pet_bus_defs.svh $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+verilog --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/pet_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module pet_bus_checker (
    input  wire                     sys_clock_i,
    input  wire                     rst_ni,
    input  pet_bus_pkg::wb_req_t    wb_req_i,
    input  pet_bus_pkg::wb_rsp_t    wb_rsp_i,
    input  wire                     cpu_be_i,
    input  wire                     cpu_clock_i,
    input  wire                     cpu_data_oe_i,
    input  wire                     bridge_strobe_i,    // Bridge oe or we before the pin mux
    input  wire  [7:0]              pins_i,             // {oe, we, io, pia1, pia2, via, a10, a11}
    input  wire  [2:0]              cpu_ctl_i,          // {nmi, ready, reset}
    input  wire                     rd_check_i,
    input  wire  [`DATA_WIDTH-1:0]  rd_exp_i,
    input  wire                     pin_check_i,
    input  wire  [7:0]              pin_exp_i,
    input  wire  [7:0]              pin_mask_i,
    input  wire                     ctl_check_i,
    input  wire  [2:0]              ctl_exp_i,
    output int                      value_errors_o,
    output int                      protocol_errors_o,
    output int                      checks_o
);
    logic ram_ack;
    logic ack_seen;     // Ack in the previous cycle
    int   exp_phase;

    assign ram_ack = wb_rsp_i.ack && !wb_req_i.addr[`WB_ADDR_WIDTH-1];

    function automatic string pin_name(input int bit_idx);
        case (bit_idx)
            7:       return "ram_oe_o";
            6:       return "ram_we_o";
            5:       return "io_oe_o";
            4:       return "pia1_cs_o";
            3:       return "pia2_cs_o";
            2:       return "via_cs_o";
            1:       return "ram_addr_a10_o";
            default: return "ram_addr_a11_o";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks_o++;
        if (got !== exp) begin
            value_errors_o++;
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors_o++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    initial begin
        value_errors_o    = 0;
        protocol_errors_o = 0;
        checks_o          = 0;
    end

    // Sampled on the rising edge, inputs settled since the falling edge
    always @(posedge sys_clock_i) begin
        if (!rst_ni) begin
            exp_phase = 0;
            ack_seen  = 1'b0;
        end else begin
            // Ownership expected from the phase within the CPU cycle
            compare_value("cpu_be_o", 8'(exp_phase >= `CPU_PHASE), 8'(cpu_be_i));
            compare_value("cpu_clock_o", 8'(exp_phase >= `CLK_HIGH_PHASE), 8'(cpu_clock_i));
            exp_phase = (exp_phase + 1) % `CYCLE_LEN;

            if (ram_ack && cpu_be_i) protocol_error("RAM ack arrived while the CPU owned the bus");
            if (bridge_strobe_i && cpu_be_i) protocol_error("bridge RAM strobe overlapped cpu_be_o");
            if (cpu_data_oe_i && cpu_be_i) protocol_error("data bus driven during CPU ownership");
            if (wb_rsp_i.ack && ack_seen) protocol_error("ack held for more than one cycle");
            ack_seen = wb_rsp_i.ack;
            if (pins_i[6] && cpu_be_i && !cpu_clock_i) begin
                protocol_error("RAM write strobe while the CPU clock was low");
            end
            if (rd_check_i && wb_rsp_i.ack) begin
                compare_value("wb_rsp_o.data", rd_exp_i, wb_rsp_i.data);
            end
            if (pin_check_i) begin
                for (int b = 0; b < 8; b++) begin
                    if (pin_mask_i[b]) compare_value(pin_name(b), 8'(pin_exp_i[b]), 8'(pins_i[b]));
                end
            end
            if (ctl_check_i) begin
                compare_value("cpu_reset_o", 8'(ctl_exp_i[0]), 8'(cpu_ctl_i[0]));
                compare_value("cpu_ready_o", 8'(ctl_exp_i[1]), 8'(cpu_ctl_i[1]));
                compare_value("cpu_nmi_o", 8'(ctl_exp_i[2]), 8'(cpu_ctl_i[2]));
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/pet_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module pet_bus_tb;
    import pet_bus_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_ROWS       = 33;
    localparam int CYCLES_PER_ROW = 40;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW;
    localparam int RAM_WORDS      = 1 << `RAM_ADDR_WIDTH;
    localparam logic CFG_CRT      = 1'b1;
    localparam logic CFG_KBD      = 1'b1;
    localparam logic CFG_GRAPHIC  = 1'b0;

    typedef enum logic [2:0] {OP_IDLE, OP_CTL, OP_WB_RD, OP_WB_WR, OP_CPU_RD, OP_CPU_WR} op_e;

    logic sys_clock;
    logic rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic [15:0] cpu_addr, cpu_addr_out, addr_bus;
    logic [7:0] cpu_data_out, cpu_drive, data_bus;
    logic cpu_addr_oe, cpu_data_oe, cpu_we, cpu_be, cpu_clock;
    logic cpu_reset, cpu_ready, cpu_nmi;
    logic a10, a11, a15, a16, ram_oe, ram_we;
    logic io_oe, pia1_cs, pia2_cs, via_cs;
    logic cfg_crt, cfg_kbd, cfg_graphic;
    logic rd_check, pin_check, ctl_check;
    logic [7:0] rd_exp, pin_exp, pin_mask;
    logic [2:0] ctl_exp;
    int value_errors, protocol_errors, checks;
    int cycle_count = 0;
    int seed = 32'h35694a12;

    op_e row_op [NUM_ROWS];
    logic [17:0] row_addr [NUM_ROWS];
    logic [7:0] row_data [NUM_ROWS];
    logic [7:0] row_exp [NUM_ROWS];
    int n_rows = 0;

    logic [7:0] ram_mem [RAM_WORDS];
    logic [16:0] ram_addr;

    // Shared address and data buses with RAM model
    assign addr_bus = cpu_addr_oe ? cpu_addr_out : cpu_addr;
    assign ram_addr = {a16, a15, addr_bus[14:12], a11, a10, addr_bus[9:0]};
    assign data_bus = ram_oe ? ram_mem[ram_addr] : (cpu_data_oe ? cpu_data_out : cpu_drive);

    always @(posedge sys_clock) begin
        if (ram_we) ram_mem[ram_addr] <= data_bus;
    end

    function automatic logic [7:0] fill_value(input logic [16:0] a);
        return a[7:0] ^ a[15:8] ^ {7'd0, a[16]};
    endfunction

    function automatic logic [17:0] reg_addr(input reg_index_e idx);
        return {1'b1, 15'd0, idx};
    endfunction

    pet_bus_top pet_bus_top_inst (
        .sys_clock_i(sys_clock), .rst_ni(rst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
        .cpu_addr_i(cpu_addr), .cpu_addr_o(cpu_addr_out), .cpu_addr_oe_o(cpu_addr_oe),
        .cpu_data_i(data_bus), .cpu_data_o(cpu_data_out), .cpu_data_oe_o(cpu_data_oe),
        .cpu_we_i(cpu_we), .cpu_be_o(cpu_be), .cpu_clock_o(cpu_clock),
        .cpu_reset_o(cpu_reset), .cpu_ready_o(cpu_ready), .cpu_nmi_o(cpu_nmi),
        .ram_addr_a10_o(a10), .ram_addr_a11_o(a11), .ram_addr_a15_o(a15),
        .ram_addr_a16_o(a16), .ram_oe_o(ram_oe), .ram_we_o(ram_we),
        .io_oe_o(io_oe), .pia1_cs_o(pia1_cs), .pia2_cs_o(pia2_cs), .via_cs_o(via_cs),
        .config_crt_i(cfg_crt), .config_keyboard_i(cfg_kbd), .graphic_i(cfg_graphic)
    );

    pet_bus_checker pet_bus_checker_inst (
        .sys_clock_i(sys_clock), .rst_ni(rst_n), .wb_req_i(wb_req), .wb_rsp_i(wb_rsp),
        .cpu_be_i(cpu_be), .cpu_clock_i(cpu_clock), .cpu_data_oe_i(cpu_data_oe),
        .bridge_strobe_i(pet_bus_top_inst.ram_ctl.oe || pet_bus_top_inst.ram_ctl.we),
        .pins_i({ram_oe, ram_we, io_oe, pia1_cs, pia2_cs, via_cs, a10, a11}),
        .cpu_ctl_i({cpu_nmi, cpu_ready, cpu_reset}),
        .rd_check_i(rd_check), .rd_exp_i(rd_exp),
        .pin_check_i(pin_check), .pin_exp_i(pin_exp), .pin_mask_i(pin_mask),
        .ctl_check_i(ctl_check), .ctl_exp_i(ctl_exp),
        .value_errors_o(value_errors), .protocol_errors_o(protocol_errors), .checks_o(checks)
    );

    initial begin
        sys_clock = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clock = ~sys_clock;
    end

    always @(posedge sys_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic add_row(input op_e op, input logic [17:0] addr, input logic [7:0] data,
                           input logic [7:0] exp);
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = exp;
        n_rows++;
    endtask

    task automatic build_table();
        logic [17:0] rnd_addr;
        logic [7:0]  rnd_data;
        logic [7:0]  status;
        rnd_addr = {1'b0, 17'($random(seed))};
        rnd_data = 8'($random(seed));
        status   = {5'd0, CFG_GRAPHIC, CFG_KBD, CFG_CRT};
        add_row(OP_IDLE, 18'h0, 8'h00, 8'h00);                  // Strobes and selects quiet
        add_row(OP_CTL, 18'h0, 8'h00, 8'h01);                   // CPU held in reset
        add_row(OP_WB_RD, reg_addr(REG_STATUS), 8'h00, status);
        add_row(OP_WB_WR, reg_addr(REG_STATUS), 8'hFF, 8'h00);
        add_row(OP_WB_RD, reg_addr(REG_STATUS), 8'h00, status);
        add_row(OP_WB_WR, reg_addr(REG_CPU), 8'h06, 8'h00);
        add_row(OP_WB_RD, reg_addr(REG_CPU), 8'h00, 8'h06);
        add_row(OP_CTL, 18'h0, 8'h00, 8'h06);
        add_row(OP_WB_WR, reg_addr(REG_CPU), 8'h03, 8'h00);
        add_row(OP_WB_RD, reg_addr(REG_CPU), 8'h00, 8'h03);
        add_row(OP_CTL, 18'h0, 8'h00, 8'h03);
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h07, 8'h00);
        add_row(OP_WB_RD, reg_addr(REG_VIDEO), 8'h00, 8'h07);
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h00, 8'h00);
        add_row(OP_WB_WR, rnd_addr, rnd_data, 8'h00);
        add_row(OP_WB_RD, rnd_addr, 8'h00, rnd_data);
        add_row(OP_CPU_WR, 18'h00123, 8'h5A, 8'h40);            // Only ram_we_o
        add_row(OP_WB_RD, 18'h00123, 8'h00, 8'h5A);
        add_row(OP_CPU_WR, 18'h0F000, 8'hA5, 8'h00);            // Read-only, no strobe
        add_row(OP_WB_RD, 18'h0F000, 8'h00, fill_value(17'h0F000));
        add_row(OP_CPU_RD, 18'h09000, 8'h00, 8'h80);
        add_row(OP_CPU_RD, 18'h0E810, 8'h00, 8'h31);            // io_oe, PIA1, A11
        add_row(OP_CPU_RD, 18'h0E820, 8'h00, 8'h29);
        add_row(OP_CPU_RD, 18'h0E840, 8'h00, 8'h25);
        add_row(OP_CPU_RD, 18'h08C00, 8'h00, 8'h80);            // Both wrapped
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h01, 8'h00);
        add_row(OP_CPU_RD, 18'h08C00, 8'h00, 8'h82);
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h04, 8'h00);
        add_row(OP_CPU_RD, 18'h08C00, 8'h00, 8'h81);
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h02, 8'h00);   // Mask bit for A10
        add_row(OP_CPU_RD, 18'h08C00, 8'h00, 8'h82);
        add_row(OP_WB_WR, reg_addr(REG_VIDEO), 8'h00, 8'h00);
        add_row(OP_CPU_RD, 18'h00C00, 8'h00, 8'h83);            // Outside video RAM
    endtask

    // Classic cycle, request held until ack and dropped one cycle later
    task automatic wb_access(input logic write, input logic [17:0] addr, input logic [7:0] data,
                             input logic [7:0] exp);
        @(negedge sys_clock);
        wb_req.cyc  = 1'b1;
        wb_req.stb  = 1'b1;
        wb_req.we   = write;
        wb_req.addr = addr;
        wb_req.data = data;
        rd_check    = !write;
        rd_exp      = exp;
        @(negedge sys_clock);
        while (wb_rsp.ack !== 1'b1) @(negedge sys_clock);
        @(negedge sys_clock);
        wb_req   = '0;
        rd_check = 1'b0;
    endtask

    // CPU access held from the start of cpu_be_o, pins compared in the clock-high quarter
    task automatic cpu_access(input logic write, input logic [15:0] addr, input logic [7:0] data,
                              input logic [7:0] exp);
        @(negedge sys_clock);
        while (cpu_be) @(negedge sys_clock);
        while (!cpu_be) @(negedge sys_clock);
        cpu_addr  = addr;
        cpu_we    = write;
        cpu_drive = data;
        while (!cpu_clock) @(negedge sys_clock);    // Clock-low quarter comes first
        pin_check = 1'b1;
        pin_exp   = exp;
        pin_mask  = 8'hFF;
        @(negedge sys_clock);
        pin_check = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = 16'h0;
        cpu_drive = 8'h00;
    endtask

    task automatic check_idle_pins(input logic [7:0] exp);
        @(negedge sys_clock);
        while (cpu_be) @(negedge sys_clock);
        pin_check = 1'b1;
        pin_exp   = exp;
        pin_mask  = 8'hFC;      // Bridge address bits not yet loaded
        @(negedge sys_clock);
        pin_check = 1'b0;
    endtask

    task automatic check_cpu_ctl(input logic [2:0] exp);
        @(negedge sys_clock);
        ctl_check = 1'b1;
        ctl_exp   = exp;
        @(negedge sys_clock);
        ctl_check = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        wb_req      = '0;
        cpu_addr    = 16'h0;
        cpu_we      = 1'b0;
        cpu_drive   = 8'h00;
        cfg_crt     = CFG_CRT;
        cfg_kbd     = CFG_KBD;
        cfg_graphic = CFG_GRAPHIC;
        rd_check    = 1'b0;
        rd_exp      = 8'h00;
        pin_check   = 1'b0;
        pin_exp     = 8'h00;
        pin_mask    = 8'h00;
        ctl_check   = 1'b0;
        ctl_exp     = 3'b000;
        for (int a = 0; a < RAM_WORDS; a++) ram_mem[a] = fill_value(a[16:0]);
        build_table();
        repeat (RESET_CYCLES) @(posedge sys_clock);
        @(negedge sys_clock);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            case (row_op[i])
                OP_IDLE:   check_idle_pins(row_exp[i]);
                OP_CTL:    check_cpu_ctl(row_exp[i][2:0]);
                OP_WB_RD:  wb_access(1'b0, row_addr[i], 8'h00, row_exp[i]);
                OP_WB_WR:  wb_access(1'b1, row_addr[i], row_data[i], 8'h00);
                OP_CPU_RD: cpu_access(1'b0, row_addr[i][15:0], 8'h00, row_exp[i]);
                default:   cpu_access(1'b1, row_addr[i][15:0], row_data[i], row_exp[i]);
            endcase
        end
        repeat (2) @(negedge sys_clock);
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pet_bus.f ====
+incdir+verilog
verilog/pet_bus_pkg.sv
verilog/bus_timing.sv
verilog/wb_ram_bridge.sv
verilog/control_regs.sv
verilog/address_decode.sv
verilog/pet_bus_top.sv
bench/pet_bus_checker.sv
bench/pet_bus_tb.sv

// ==== verilog/address_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module address_decode (
    input  wire  [`CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    output pet_bus_pkg::decode_t       decode_o
);
    logic in_vram;
    logic in_rom;
    logic in_io;
    logic in_rom2;

    // Region compares on the full CPU address
    always_comb begin
        in_vram = (cpu_addr_i >= `VRAM_BASE) && (cpu_addr_i < `ROM_BASE);
        in_rom  = (cpu_addr_i >= `ROM_BASE) && (cpu_addr_i < `IO_BASE);
        in_io   = (cpu_addr_i >= `IO_BASE) && (cpu_addr_i <= `IO_END);
        in_rom2 = (cpu_addr_i >= `ROM2_BASE);
    end

    always_comb begin
        decode_o.ram_en      = !in_io;              // Everything outside I/O is backed by RAM
        decode_o.is_vram     = in_vram;
        decode_o.is_readonly = in_rom || in_rom2;   // ROM images live in RAM
        decode_o.io_en       = in_io;

        // One address bit per chip inside the I/O page
        decode_o.pia1_en     = in_io && cpu_addr_i[`PIA1_BIT];
        decode_o.pia2_en     = in_io && cpu_addr_i[`PIA2_BIT];
        decode_o.via_en      = in_io && cpu_addr_i[`VIA_BIT];
    end

endmodule

`default_nettype wire

// ==== verilog/bus_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module bus_timing (
    input  wire  sys_clock_i,
    input  wire  rst_ni,
    output logic cpu_be_o,              // CPU owns the RAM
    output logic cpu_clock_o,
    output logic cpu_data_strobe_o,     // Last clock of the CPU cycle
    output logic wb_window_o            // Bridge may start an access
);
    localparam int PHASE_W = $clog2(`CYCLE_LEN);

    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(`CYCLE_LEN - 1);
    localparam logic [PHASE_W-1:0] BE_PHASE   = PHASE_W'(`CPU_PHASE);
    localparam logic [PHASE_W-1:0] CLK_PHASE  = PHASE_W'(`CLK_HIGH_PHASE);
    localparam logic [PHASE_W-1:0] SAFE_PHASE = PHASE_W'(`LAST_SAFE_PHASE);

    logic [PHASE_W-1:0] phase_q;
    logic [PHASE_W-1:0] phase_next;

    always_comb begin
        if (phase_q == LAST_PHASE) begin
            phase_next = '0;
        end else begin
            phase_next = phase_q + 1'b1;
        end
    end

    // Decodes use the next phase so the outputs line up with phase_q
    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q           <= '0;
            cpu_be_o          <= 1'b0;
            cpu_clock_o       <= 1'b0;
            cpu_data_strobe_o <= 1'b0;
            wb_window_o       <= 1'b1;  // Phase 0 opens the window
        end else begin
            phase_q           <= phase_next;
            cpu_be_o          <= (phase_next >= BE_PHASE);
            cpu_clock_o       <= (phase_next >= CLK_PHASE);
            cpu_data_strobe_o <= (phase_next == LAST_PHASE);
            wb_window_o       <= (phase_next <= SAFE_PHASE);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/control_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module control_regs (
    input  wire                      sys_clock_i,
    input  wire                      rst_ni,
    input  pet_bus_pkg::wb_req_t     wb_req_i,
    output pet_bus_pkg::wb_rsp_t     wb_rsp_o,
    input  wire                      config_crt_i,       // Display type switch
    input  wire                      config_keyboard_i,  // Keyboard type switch
    input  wire                      graphic_i,          // Character set select from VIA
    output pet_bus_pkg::cpu_ctl_t    cpu_ctl_o,
    output pet_bus_pkg::video_ctl_t  video_ctl_o
);
    import pet_bus_pkg::*;

    reg_index_e             reg_idx;
    logic                   req;
    logic                   ack_q;
    logic [`DATA_WIDTH-1:0] rdata_q;
    logic [2:0]             status;

    assign reg_idx = reg_index_e'(wb_req_i.addr[`REG_IDX_WIDTH-1:0]);
    assign req     = wb_req_i.cyc && wb_req_i.stb && !ack_q;   // One ack per request
    assign status  = {graphic_i, config_keyboard_i, config_crt_i};

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q       <= 1'b0;
            cpu_ctl_o   <= '{reset: 1'b1, ready: 1'b0, nmi: 1'b0};  // Hold CPU in reset
            video_ctl_o <= '0;
        end else begin
            ack_q <= req;
            if (req && wb_req_i.we) begin
                case (reg_idx)
                    REG_CPU:   cpu_ctl_o   <= cpu_ctl_t'(wb_req_i.data[$bits(cpu_ctl_t)-1:0]);
                    REG_VIDEO: video_ctl_o <= video_ctl_t'(wb_req_i.data[$bits(video_ctl_t)-1:0]);
                    default:   ;    // Status is read-only
                endcase
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (req && !wb_req_i.we) begin
            case (reg_idx)
                REG_STATUS: rdata_q <= `DATA_WIDTH'(status);
                REG_CPU:    rdata_q <= `DATA_WIDTH'(cpu_ctl_o);
                REG_VIDEO:  rdata_q <= `DATA_WIDTH'(video_ctl_o);
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack  = ack_q;
    assign wb_rsp_o.data = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/pet_bus_defs.svh ====
`ifndef PET_BUS_DEFS_SVH
`define PET_BUS_DEFS_SVH

// Bus widths
`define DATA_WIDTH      8
`define CPU_ADDR_WIDTH  16
`define RAM_ADDR_WIDTH  17
`define WB_ADDR_WIDTH   18      // Bit 17 set selects the register file

// Phases of one CPU cycle, counted in system clocks
`define CYCLE_LEN       16
`define CPU_PHASE       8       // CPU owns the RAM from here to the end
`define CLK_HIGH_PHASE  12
`define LAST_SAFE_PHASE 4       // Latest start for a bridge access

// CPU memory map
`define VRAM_BASE       16'h8000
`define ROM_BASE        16'h9000
`define IO_BASE         16'hE800
`define IO_END          16'hEFFF
`define ROM2_BASE       16'hF000

// Chip selects inside the I/O page
`define PIA1_BIT        4
`define PIA2_BIT        5
`define VIA_BIT         6

// Register file indices
`define REG_IDX_WIDTH   2
`define REG_STATUS_IDX  0
`define REG_CPU_IDX     1
`define REG_VIDEO_IDX   2

`endif

// ==== verilog/pet_bus_pkg.sv ====
`default_nettype none

`include "pet_bus_defs.svh"

package pet_bus_pkg;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`WB_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]    data;    // Host to target
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`DATA_WIDTH-1:0] data;       // Target to host
    } wb_rsp_t;

    typedef struct packed {
        logic                       oe;
        logic                       we;
        logic [`RAM_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
        logic                       data_oe;    // Bridge drives the data bus
    } ram_ctl_t;

    // Bit 0 is reset, matching the register layout
    typedef struct packed {
        logic nmi;
        logic ready;
        logic reset;
    } cpu_ctl_t;

    typedef struct packed {
        logic [1:0] ram_mask;   // [0] keeps A10, [1] keeps A11
        logic       col_80;
    } video_ctl_t;

    typedef struct packed {
        logic ram_en;
        logic is_vram;
        logic is_readonly;
        logic io_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
    } decode_t;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_ACCESS,
        RAM_ACK
    } ram_state_e;

    typedef enum logic [`REG_IDX_WIDTH-1:0] {
        REG_STATUS = `REG_IDX_WIDTH'(`REG_STATUS_IDX),
        REG_CPU    = `REG_IDX_WIDTH'(`REG_CPU_IDX),
        REG_VIDEO  = `REG_IDX_WIDTH'(`REG_VIDEO_IDX)
    } reg_index_e;

endpackage

`default_nettype wire

// ==== verilog/pet_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module pet_bus_top (
    input  wire                         sys_clock_i,
    input  wire                         rst_ni,

    // Wishbone host port
    input  pet_bus_pkg::wb_req_t        wb_req_i,
    output pet_bus_pkg::wb_rsp_t        wb_rsp_o,

    // CPU
    input  wire  [`CPU_ADDR_WIDTH-1:0]  cpu_addr_i,
    output logic [`CPU_ADDR_WIDTH-1:0]  cpu_addr_o,
    output logic                        cpu_addr_oe_o,
    input  wire  [`DATA_WIDTH-1:0]      cpu_data_i,
    output logic [`DATA_WIDTH-1:0]      cpu_data_o,
    output logic                        cpu_data_oe_o,
    input  wire                         cpu_we_i,
    output logic                        cpu_be_o,
    output logic                        cpu_clock_o,
    output logic                        cpu_reset_o,
    output logic                        cpu_ready_o,
    output logic                        cpu_nmi_o,

    // RAM
    output logic                        ram_addr_a10_o,
    output logic                        ram_addr_a11_o,
    output logic                        ram_addr_a15_o,
    output logic                        ram_addr_a16_o,
    output logic                        ram_oe_o,
    output logic                        ram_we_o,

    // I/O chips
    output logic                        io_oe_o,
    output logic                        pia1_cs_o,
    output logic                        pia2_cs_o,
    output logic                        via_cs_o,

    // Configuration pins
    input  wire                         config_crt_i,
    input  wire                         config_keyboard_i,
    input  wire                         graphic_i
);
    import pet_bus_pkg::*;

    wb_req_t    ram_req;
    wb_req_t    reg_req;
    wb_rsp_t    ram_rsp;
    wb_rsp_t    reg_rsp;
    ram_ctl_t   ram_ctl;
    cpu_ctl_t   cpu_ctl;
    video_ctl_t video_ctl;
    decode_t    dec;
    logic       wb_window;
    logic       reg_sel;
    logic       cpu_rd_en;
    logic       cpu_wr_en;

    bus_timing bus_timing_inst (
        .sys_clock_i       (sys_clock_i),
        .rst_ni            (rst_ni),
        .cpu_be_o          (cpu_be_o),
        .cpu_clock_o       (cpu_clock_o),
        .cpu_data_strobe_o (),
        .wb_window_o       (wb_window)
    );

    // Only the selected target sees the strobe
    assign reg_sel = wb_req_i.addr[`WB_ADDR_WIDTH-1];

    always_comb begin
        ram_req     = wb_req_i;
        reg_req     = wb_req_i;
        ram_req.stb = wb_req_i.stb && !reg_sel;
        reg_req.stb = wb_req_i.stb && reg_sel;
        wb_rsp_o    = reg_sel ? reg_rsp : ram_rsp;
    end

    wb_ram_bridge wb_ram_bridge_inst (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .wb_req_i    (ram_req),
        .wb_rsp_o    (ram_rsp),
        .wb_window_i (wb_window),
        .ram_data_i  (cpu_data_i),      // RAM shares the CPU data bus
        .ram_ctl_o   (ram_ctl)
    );

    control_regs control_regs_inst (
        .sys_clock_i       (sys_clock_i),
        .rst_ni            (rst_ni),
        .wb_req_i          (reg_req),
        .wb_rsp_o          (reg_rsp),
        .config_crt_i      (config_crt_i),
        .config_keyboard_i (config_keyboard_i),
        .graphic_i         (graphic_i),
        .cpu_ctl_o         (cpu_ctl),
        .video_ctl_o       (video_ctl)
    );

    address_decode address_decode_inst (
        .cpu_addr_i (cpu_addr_i),
        .decode_o   (dec)
    );

    assign cpu_reset_o = cpu_ctl.reset;
    assign cpu_ready_o = cpu_ctl.ready;
    assign cpu_nmi_o   = cpu_ctl.nmi;

    assign cpu_rd_en = cpu_be_o && !cpu_we_i;
    assign cpu_wr_en = cpu_be_o && cpu_we_i && cpu_clock_o;   // Write in the clock-high quarter

    always_comb begin
        if (cpu_be_o) begin
            ram_oe_o       = cpu_rd_en && dec.ram_en;
            ram_we_o       = cpu_wr_en && dec.ram_en && !dec.is_readonly;
            // Wrap video RAM unless the mask or 80 columns keep the bit
            ram_addr_a10_o = cpu_addr_i[10]
                             && (!dec.is_vram || video_ctl.ram_mask[0] || video_ctl.col_80);
            ram_addr_a11_o = cpu_addr_i[11] && (!dec.is_vram || video_ctl.ram_mask[1]);
            ram_addr_a15_o = cpu_addr_i[15];
            ram_addr_a16_o = 1'b0;              // CPU sees the lower 64K only
        end else begin
            ram_oe_o       = ram_ctl.oe;
            ram_we_o       = ram_ctl.we;
            ram_addr_a10_o = ram_ctl.addr[10];
            ram_addr_a11_o = ram_ctl.addr[11];
            ram_addr_a15_o = ram_ctl.addr[15];
            ram_addr_a16_o = ram_ctl.addr[16];
        end
    end

    // Bus turnaround follows ownership
    assign cpu_addr_o    = ram_ctl.addr[`CPU_ADDR_WIDTH-1:0];
    assign cpu_addr_oe_o = !cpu_be_o;
    assign cpu_data_o    = ram_ctl.data;
    assign cpu_data_oe_o = !cpu_be_o && ram_ctl.data_oe;

    assign io_oe_o   = cpu_be_o && dec.io_en;
    assign pia1_cs_o = cpu_be_o && dec.pia1_en;
    assign pia2_cs_o = cpu_be_o && dec.pia2_en;
    assign via_cs_o  = cpu_be_o && dec.via_en;

endmodule

`default_nettype wire

// ==== verilog/wb_ram_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_defs.svh"

module wb_ram_bridge (
    input  wire                        sys_clock_i,
    input  wire                        rst_ni,
    input  pet_bus_pkg::wb_req_t       wb_req_i,
    output pet_bus_pkg::wb_rsp_t       wb_rsp_o,
    input  wire                        wb_window_i,
    input  wire  [`DATA_WIDTH-1:0]     ram_data_i,     // Shared data bus
    output pet_bus_pkg::ram_ctl_t      ram_ctl_o
);
    import pet_bus_pkg::*;

    ram_state_e                 state_q;
    logic                       access_cnt_q;   // Second access cycle when set
    logic                       we_q;
    logic [`RAM_ADDR_WIDTH-1:0] addr_q;
    logic [`DATA_WIDTH-1:0]     wdata_q;
    logic [`DATA_WIDTH-1:0]     rdata_q;
    logic                       accept;

    // Requests are only taken early enough to finish before the CPU half
    assign accept = (state_q == RAM_IDLE) && wb_req_i.cyc && wb_req_i.stb && wb_window_i;

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= RAM_IDLE;
            access_cnt_q <= 1'b0;
        end else begin
            unique case (state_q)
                RAM_IDLE: begin
                    access_cnt_q <= 1'b0;
                    if (accept) begin
                        state_q <= RAM_ACCESS;
                    end
                end
                RAM_ACCESS: begin
                    access_cnt_q <= 1'b1;
                    if (access_cnt_q) begin
                        state_q <= RAM_ACK;
                    end
                end
                default: begin
                    state_q <= RAM_IDLE;    // Ack lasts one cycle
                end
            endcase
        end
    end

    // Request payload, held for the whole access
    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            we_q    <= wb_req_i.we;
            addr_q  <= wb_req_i.addr[`RAM_ADDR_WIDTH-1:0];
            wdata_q <= wb_req_i.data;
        end
        if (state_q == RAM_ACCESS && access_cnt_q) begin
            rdata_q <= ram_data_i;  // Sample in the last access cycle
        end
    end

    always_comb begin
        ram_ctl_o.oe      = (state_q == RAM_ACCESS) && !we_q;
        ram_ctl_o.we      = (state_q == RAM_ACCESS) && we_q;
        ram_ctl_o.data_oe = (state_q == RAM_ACCESS) && we_q;
        ram_ctl_o.addr    = addr_q;
        ram_ctl_o.data    = wdata_q;
        wb_rsp_o.ack      = (state_q == RAM_ACK);
        wb_rsp_o.data     = rdata_q;
    end

endmodule

`default_nettype wire
